// File: common/noc_pkg.sv
`default_nettype none

package noc_pkg;

    localparam int NOC_DATA_WIDTH  = 64;
    localparam int COORD_WIDTH     = 8;
    localparam int MSG_TYPE_WIDTH  = 8;
    localparam int BODY_LEN_WIDTH  = 8;
    localparam int ADDR_WIDTH      = 64;

    localparam int MAX_BODY_FLITS  = 8;
    localparam int BODY_FIFO_DEPTH = 8;
    localparam int BODY_PTR_WIDTH  = $clog2(BODY_FIFO_DEPTH);

    // bits left over in the route flit after the six byte fields
    localparam int HDR_RSVD_WIDTH  = NOC_DATA_WIDTH - 4 * COORD_WIDTH
                                   - MSG_TYPE_WIDTH - BODY_LEN_WIDTH;

    typedef logic [NOC_DATA_WIDTH-1:0] flit_t;
    typedef logic [COORD_WIDTH-1:0]    coord_t;
    typedef logic [MSG_TYPE_WIDTH-1:0] msg_type_t;
    typedef logic [BODY_LEN_WIDTH-1:0] body_len_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;

    typedef logic [BODY_PTR_WIDTH-1:0] body_ptr_t;
    typedef logic [BODY_PTR_WIDTH:0]   body_cnt_t;   // one extra bit to tell full from empty

    localparam msg_type_t MSG_LOAD_REQ  = 8'd1;
    localparam msg_type_t MSG_STORE_REQ = 8'd2;
    localparam msg_type_t MSG_RESP      = 8'd3;

    // 96-bit request from the client
    typedef struct packed {
        coord_t    dst_x;
        coord_t    dst_y;
        msg_type_t msg_type;
        body_len_t body_len;
        addr_t     addr;      // only sent for load and store
    } noc_req_t;

    typedef struct packed {
        flit_t data;
        logic  last;
    } body_word_t;

    // header flit 0 laid out msb first
    typedef struct packed {
        coord_t                    dst_x;
        coord_t                    dst_y;
        msg_type_t                 msg_type;
        body_len_t                 body_len;
        coord_t                    src_x;
        coord_t                    src_y;
        logic [HDR_RSVD_WIDTH-1:0] rsvd;
    } hdr_route_t;

endpackage

`default_nettype wire

// File: noc_tx/noc_hdr_gen.sv
`default_nettype none

module noc_hdr_gen (
     input  wire                        clk
    ,input  wire                        rst

    ,input  wire                        req_val
    ,input  wire    noc_pkg::noc_req_t  req
    ,output logic                       req_rdy

    ,input  wire    noc_pkg::coord_t    my_x
    ,input  wire    noc_pkg::coord_t    my_y

    ,output logic                       hdr_val
    ,output noc_pkg::flit_t             hdr_data
    ,output logic                       hdr_last
    ,input  wire                        hdr_rdy
);

    import noc_pkg::*;

    typedef enum logic [1:0] {
        HDR_IDLE  = 2'd0,
        HDR_ROUTE = 2'd1,
        HDR_ADDR  = 2'd2
    } hdr_state_e;

    hdr_state_e state_reg;
    hdr_state_e state_next;

    noc_req_t   req_reg;
    hdr_route_t route_flit;

    logic has_addr;
    logic last_taken;
    logic req_take;

    assign has_addr = (req_reg.msg_type == MSG_LOAD_REQ)
                   || (req_reg.msg_type == MSG_STORE_REQ);

    assign hdr_val    = state_reg != HDR_IDLE;
    assign hdr_last   = (state_reg == HDR_ADDR) || ((state_reg == HDR_ROUTE) && !has_addr);
    assign last_taken = hdr_val & hdr_rdy & hdr_last;

    // a new request can slip in on the cycle the final header flit leaves
    assign req_rdy  = (state_reg == HDR_IDLE) | last_taken;
    assign req_take = req_val & req_rdy;

    always_comb begin
        route_flit          = '0;
        route_flit.dst_x    = req_reg.dst_x;
        route_flit.dst_y    = req_reg.dst_y;
        route_flit.msg_type = req_reg.msg_type;
        route_flit.body_len = req_reg.body_len;
        route_flit.src_x    = my_x;    // own tile position
        route_flit.src_y    = my_y;
    end

    assign hdr_data = (state_reg == HDR_ADDR) ? req_reg.addr : route_flit;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            HDR_IDLE: begin
                if (req_take) begin
                    state_next = HDR_ROUTE;
                end
            end
            HDR_ROUTE: begin
                if (hdr_rdy && has_addr) begin
                    state_next = HDR_ADDR;
                end
                else if (hdr_rdy) begin
                    state_next = req_take ? HDR_ROUTE : HDR_IDLE;
                end
            end
            HDR_ADDR: begin
                if (hdr_rdy) begin
                    state_next = req_take ? HDR_ROUTE : HDR_IDLE;
                end
            end
            default: begin
                state_next = HDR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HDR_IDLE;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            req_reg <= req;
        end
    end

endmodule

`default_nettype wire

// File: noc_tx/noc_body_fifo.sv
`default_nettype none

module noc_body_fifo (
     input  wire                        clk
    ,input  wire                        rst

    ,input  wire                        wr_val
    ,input  wire    noc_pkg::body_word_t wr_word
    ,output logic                       wr_rdy

    ,output logic                       rd_val
    ,output noc_pkg::flit_t             rd_data
    ,output logic                       rd_last
    ,input  wire                        rd_rdy
);

    import noc_pkg::*;

    body_word_t mem [BODY_FIFO_DEPTH];

    body_ptr_t  wr_ptr;
    body_ptr_t  rd_ptr;
    body_cnt_t  count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    function automatic body_ptr_t ptr_inc(input body_ptr_t ptr);
        body_ptr_t nxt;
        if (ptr == body_ptr_t'(BODY_FIFO_DEPTH - 1)) begin
            nxt = '0;
        end
        else begin
            nxt = ptr + body_ptr_t'(1);
        end
        return nxt;
    endfunction

    assign full  = count == body_cnt_t'(BODY_FIFO_DEPTH);
    assign empty = count == '0;

    assign rd_val  = !empty;
    assign rd_data = mem[rd_ptr].data;
    assign rd_last = mem[rd_ptr].last;

    // a full buffer still takes a word when the head leaves in the same cycle
    assign wr_rdy = !full | rd_rdy;

    assign wr_en = wr_val & wr_rdy;
    assign rd_en = rd_val & rd_rdy;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end
        else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + body_cnt_t'(1);
                2'b01:   count <= count - body_cnt_t'(1);
                default: count <= count;    // idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// File: noc_tx/flit_hdr_join.sv
`default_nettype none

module flit_hdr_join (
     input  wire                    clk
    ,input  wire                    rst

    ,input  wire                    src_join_hdr_val
    ,input  wire    noc_pkg::flit_t src_join_hdr_data
    ,input  wire                    src_join_hdr_last
    ,output logic                   join_src_hdr_rdy

    ,input  wire                    src_join_body_val
    ,input  wire                    src_join_body_last
    ,input  wire    noc_pkg::flit_t src_join_body_data
    ,output logic                   join_src_body_rdy

    ,output logic                   join_dst_val
    ,output noc_pkg::flit_t         join_dst_data
    ,input  wire                    dst_join_rdy
);

    typedef enum logic {
        HDR_PASS  = 1'b0,
        BODY_PASS = 1'b1
    } join_state_e;

    join_state_e state_reg;
    join_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HDR_PASS;
        end
        else begin
            state_reg <= state_next;
        end
    end

    assign join_dst_data = (state_reg == HDR_PASS) ? src_join_hdr_data : src_join_body_data;

    // only the selected source sees the downstream ready
    always_comb begin
        join_dst_val      = 1'b0;
        join_src_hdr_rdy  = 1'b0;
        join_src_body_rdy = 1'b0;
        state_next        = state_reg;

        case (state_reg)
            HDR_PASS: begin
                join_dst_val     = src_join_hdr_val;
                join_src_hdr_rdy = dst_join_rdy;
                if (src_join_hdr_val && dst_join_rdy && src_join_hdr_last) begin
                    state_next = BODY_PASS;
                end
            end
            BODY_PASS: begin
                join_dst_val      = src_join_body_val;
                join_src_body_rdy = dst_join_rdy;
                if (src_join_body_val && dst_join_rdy && src_join_body_last) begin
                    state_next = HDR_PASS;   // message done
                end
            end
            default: begin
                state_next = HDR_PASS;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/noc_tx_top.sv
`default_nettype none

module noc_tx_top (
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            req_val
    ,input  wire    noc_pkg::noc_req_t      req
    ,output logic                           req_rdy

    ,input  wire                            body_val
    ,input  wire    noc_pkg::body_word_t    body_word
    ,output logic                           body_rdy

    ,input  wire    noc_pkg::coord_t        my_x
    ,input  wire    noc_pkg::coord_t        my_y

    ,output logic                           noc_val
    ,output noc_pkg::flit_t                 noc_data
    ,input  wire                            noc_rdy
);

    import noc_pkg::*;

    // header generator to join
    logic   hdr_val;
    flit_t  hdr_data;
    logic   hdr_last;
    logic   hdr_rdy;

    // body FIFO to join
    logic   fifo_val;
    flit_t  fifo_data;
    logic   fifo_last;
    logic   fifo_rdy;

    noc_hdr_gen u_hdr_gen (
         .clk       (clk)
        ,.rst       (rst)
        ,.req_val   (req_val)
        ,.req       (req)
        ,.req_rdy   (req_rdy)
        ,.my_x      (my_x)
        ,.my_y      (my_y)
        ,.hdr_val   (hdr_val)
        ,.hdr_data  (hdr_data)
        ,.hdr_last  (hdr_last)
        ,.hdr_rdy   (hdr_rdy)
    );

    noc_body_fifo u_body_fifo (
         .clk       (clk)
        ,.rst       (rst)
        ,.wr_val    (body_val)
        ,.wr_word   (body_word)
        ,.wr_rdy    (body_rdy)
        ,.rd_val    (fifo_val)
        ,.rd_data   (fifo_data)
        ,.rd_last   (fifo_last)
        ,.rd_rdy    (fifo_rdy)
    );

    flit_hdr_join u_join (
         .clk                   (clk)
        ,.rst                   (rst)
        ,.src_join_hdr_val      (hdr_val)
        ,.src_join_hdr_data     (hdr_data)
        ,.src_join_hdr_last     (hdr_last)
        ,.join_src_hdr_rdy      (hdr_rdy)
        ,.src_join_body_val     (fifo_val)
        ,.src_join_body_last    (fifo_last)
        ,.src_join_body_data    (fifo_data)
        ,.join_src_body_rdy     (fifo_rdy)
        ,.join_dst_val          (noc_val)
        ,.join_dst_data         (noc_data)
        ,.dst_join_rdy          (noc_rdy)
    );

endmodule

`default_nettype wire

// File: verification/noc_tx_checker.sv
`default_nettype none

module noc_tx_checker (
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            req_val
    ,input  wire    noc_pkg::noc_req_t      req
    ,input  wire                            req_rdy

    ,input  wire                            body_val
    ,input  wire    noc_pkg::body_word_t    body_word
    ,input  wire                            body_rdy

    ,input  wire    noc_pkg::coord_t        my_x
    ,input  wire    noc_pkg::coord_t        my_y

    ,input  wire                            noc_val
    ,input  wire    noc_pkg::flit_t         noc_data
    ,input  wire                            noc_rdy

    ,output int                             error_count
    ,output int                             msgs_done
    ,output int                             leftover
    ,output logic                           saw_fifo_full
);

    import noc_pkg::*;

    noc_req_t   req_q[$];
    body_word_t body_q[$];
    flit_t      exp_q[$];
    logic       exp_end_q[$];     // marks the final flit of each message
    flit_t      act_q[$];
    noc_req_t   out_q[$];         // accepted requests whose flits are still on their way out

    noc_req_t   next_req;
    flit_t      exp_flit;
    flit_t      act_flit;
    flit_t      data_prev;
    logic       is_end;
    logic       req_seen;
    logic       stall_prev;

    int         out_pos;          // flit position inside the message at the head of out_q
    int         hdr_pending;      // header flits still held in the generator
    int         body_pending;     // body words sitting in the FIFO
    logic       cur_hdr;
    logic       cur_body;
    logic       exp_req_rdy;
    logic       exp_body_rdy;

    // load and store carry the address flit after the route flit
    function automatic int header_flits(input noc_req_t r);
        int n;
        n = 1;
        if (r.msg_type == MSG_LOAD_REQ || r.msg_type == MSG_STORE_REQ) begin
            n = 2;
        end
        return n;
    endfunction

    // expected flits of one message with its body words taken from the head of body_q
    function automatic void build_expected(input noc_req_t r, input coord_t sx, input coord_t sy);
        flit_t      route;
        body_word_t w;
        int         i;
        route = {r.dst_x, r.dst_y, r.msg_type, r.body_len, sx, sy, 16'h0000};
        exp_q.push_back(route);
        exp_end_q.push_back(1'b0);
        if (r.msg_type == MSG_LOAD_REQ || r.msg_type == MSG_STORE_REQ) begin
            exp_q.push_back(r.addr);
            exp_end_q.push_back(1'b0);
        end
        for (i = 0; i < int'(r.body_len); i++) begin
            w = body_q.pop_front();
            exp_q.push_back(w.data);
            exp_end_q.push_back(i == int'(r.body_len) - 1);
        end
    endfunction

    // sampled mid cycle where every DUT port has settled
    always @(negedge clk) begin
        if (rst) begin
            error_count   = 0;
            msgs_done     = 0;
            leftover      = 0;
            saw_fifo_full = 1'b0;
            req_seen      = 1'b0;
            stall_prev    = 1'b0;
            data_prev     = '0;
            out_pos       = 0;
            hdr_pending   = 0;
            body_pending  = 0;
            out_q.delete();
        end
        else begin
            if (noc_val && !req_seen) begin
                error_count++;
                $display("ERROR t=%0t noc_val expected 0 actual 1", $time);
            end
            if (stall_prev && !noc_val) begin
                error_count++;
                $display("ERROR t=%0t noc_val expected 1 actual 0", $time);
            end
            else if (stall_prev && noc_data !== data_prev) begin
                error_count++;
                $display("ERROR t=%0t noc_data expected %016h actual %016h",
                         $time, data_prev, noc_data);
            end

            cur_hdr  = 1'b0;
            cur_body = 1'b0;
            if (out_q.size() > 0) begin
                cur_hdr  = out_pos < header_flits(out_q[0]);
                cur_body = !cur_hdr;
            end

            // the generator frees up as its last header flit leaves
            exp_req_rdy  = (hdr_pending == 0)
                        || (hdr_pending == 1 && noc_val && noc_rdy && cur_hdr);
            // a full FIFO still takes a word while a body flit leaves
            exp_body_rdy = (body_pending < BODY_FIFO_DEPTH)
                        || (noc_val && noc_rdy && cur_body);
            if (req_rdy !== exp_req_rdy) begin
                error_count++;
                $display("ERROR t=%0t req_rdy expected %0b actual %0b",
                         $time, exp_req_rdy, req_rdy);
            end
            if (body_rdy !== exp_body_rdy) begin
                error_count++;
                $display("ERROR t=%0t body_rdy expected %0b actual %0b",
                         $time, exp_body_rdy, body_rdy);
            end

            if (noc_val && noc_rdy && out_q.size() > 0) begin
                if (cur_hdr) begin
                    hdr_pending--;
                end
                else begin
                    body_pending--;
                end
                out_pos++;
                if (out_pos == header_flits(out_q[0]) + int'(out_q[0].body_len)) begin
                    out_q.delete(0);
                    out_pos = 0;
                end
            end

            if (req_val && req_rdy) begin
                req_q.push_back(req);
                out_q.push_back(req);
                hdr_pending += header_flits(req);
                req_seen = 1'b1;
            end
            if (body_val && body_rdy) begin
                body_q.push_back(body_word);
                body_pending++;
            end
            if (body_val && !body_rdy) begin
                saw_fifo_full = 1'b1;
            end
            if (noc_val && noc_rdy) begin
                act_q.push_back(noc_data);
            end
            stall_prev = noc_val && !noc_rdy;
            data_prev  = noc_data;

            // a message is modeled once its request and all its body words are in
            while (req_q.size() > 0 && body_q.size() >= int'(req_q[0].body_len)) begin
                next_req = req_q.pop_front();
                build_expected(next_req, my_x, my_y);
            end

            while (exp_q.size() > 0 && act_q.size() > 0) begin
                exp_flit = exp_q.pop_front();
                act_flit = act_q.pop_front();
                is_end   = exp_end_q.pop_front();
                if (act_flit !== exp_flit) begin
                    error_count++;
                    $display("ERROR t=%0t noc_data expected %016h actual %016h",
                             $time, exp_flit, act_flit);
                end
                if (is_end) begin
                    msgs_done++;
                end
            end
            leftover = exp_q.size() + act_q.size();
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_noc_tx.sv
`default_nettype none

module tb_noc_tx;

    import noc_pkg::*;

    localparam int NUM_MSGS        = 200;
    localparam int DRIVE_DELAY     = 1;
    localparam int WATCHDOG_CYCLES = NUM_MSGS * (2 + MAX_BODY_FLITS) * 4;
    localparam int SEED            = 32'h7759bbe3;

    logic       clk;
    logic       rst;
    logic       req_val;
    noc_req_t   req;
    logic       req_rdy;
    logic       body_val;
    body_word_t body_word;
    logic       body_rdy;
    coord_t     my_x;
    coord_t     my_y;
    logic       noc_val;
    flit_t      noc_data;
    logic       noc_rdy;

    int         error_count;
    int         msgs_done;
    int         leftover;
    logic       saw_fifo_full;
    int         end_failures;

    noc_req_t   msgs [NUM_MSGS];
    flit_t      bodies [NUM_MSGS][MAX_BODY_FLITS];

    noc_tx_top uut (
         .clk(clk), .rst(rst)
        ,.req_val(req_val), .req(req), .req_rdy(req_rdy)
        ,.body_val(body_val), .body_word(body_word), .body_rdy(body_rdy)
        ,.my_x(my_x), .my_y(my_y)
        ,.noc_val(noc_val), .noc_data(noc_data), .noc_rdy(noc_rdy)
    );

    noc_tx_checker u_checker (
         .clk(clk), .rst(rst)
        ,.req_val(req_val), .req(req), .req_rdy(req_rdy)
        ,.body_val(body_val), .body_word(body_word), .body_rdy(body_rdy)
        ,.my_x(my_x), .my_y(my_y)
        ,.noc_val(noc_val), .noc_data(noc_data), .noc_rdy(noc_rdy)
        ,.error_count(error_count), .msgs_done(msgs_done)
        ,.leftover(leftover), .saw_fifo_full(saw_fifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    function automatic void build_messages();
        int m;
        int i;
        for (m = 0; m < NUM_MSGS; m++) begin
            msgs[m].dst_x    = coord_t'($urandom);
            msgs[m].dst_y    = coord_t'($urandom);
            msgs[m].msg_type = msg_type_t'($urandom_range(3, 1));
            msgs[m].addr     = {$urandom, $urandom};
            if (m % 10 == 0) begin
                msgs[m].body_len = body_len_t'(1);
            end
            else if (m % 10 == 1) begin
                msgs[m].body_len = body_len_t'(MAX_BODY_FLITS);
            end
            else begin
                msgs[m].body_len = body_len_t'($urandom_range(MAX_BODY_FLITS, 1));
            end
            for (i = 0; i < MAX_BODY_FLITS; i++) begin
                bodies[m][i] = {$urandom, $urandom};
            end
        end
    endfunction

    task automatic drive_requests();
        int m;
        for (m = 0; m < NUM_MSGS; m++) begin
            // a slow stretch lets the bodies run far ahead and fill the FIFO
            wait_cycles((m >= 40 && m < 50) ? 30 : int'($urandom_range(3, 0)));
            req_val = 1'b1;
            req     = msgs[m];
            @(negedge clk);
            while (!req_rdy) @(negedge clk);
            wait_cycles(1);
            req_val = 1'b0;
        end
    endtask

    task automatic drive_bodies();
        int m;
        int i;
        for (m = 0; m < NUM_MSGS; m++) begin
            for (i = 0; i < int'(msgs[m].body_len); i++) begin
                wait_cycles(int'($urandom_range(1, 0)));
                body_val       = 1'b1;
                body_word.data = bodies[m][i];
                body_word.last = (i == int'(msgs[m].body_len) - 1);
                @(negedge clk);
                while (!body_rdy) @(negedge clk);
                wait_cycles(1);
                body_val = 1'b0;
            end
        end
    endtask

    // random back-pressure with a heavy stall window every 200 cycles
    initial begin
        int cyc;
        noc_rdy = 1'b0;
        cyc     = 0;
        forever begin
            wait_cycles(1);
            cyc++;
            if (cyc % 200 < 40) begin
                noc_rdy = ($urandom_range(7, 0) == 0);
            end
            else begin
                noc_rdy = ($urandom_range(3, 0) != 0);
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        req_val   = 1'b0;
        req       = '0;
        body_val  = 1'b0;
        body_word = '0;
        my_x      = 8'h3a;
        my_y      = 8'h05;
        end_failures = 0;
        build_messages();
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        fork
            drive_requests();
            drive_bodies();
        join

        while (msgs_done < NUM_MSGS) wait_cycles(1);
        wait_cycles(4);

        if (leftover != 0) begin
            end_failures++;
            $display("%0d flits were still unmatched at the end of the run", leftover);
        end
        if (!saw_fifo_full) begin
            end_failures++;
            $display("the body FIFO never pushed back on body_val");
        end
        $display("%0d errors, %0d end of run failures", error_count, end_failures);
        if (error_count == 0 && end_failures == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT seems to hang", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/noc_pkg.sv
noc_tx/noc_hdr_gen.sv
noc_tx/noc_body_fifo.sv
noc_tx/flit_hdr_join.sv
hw/noc_tx_top.sv
verification/noc_tx_checker.sv
verification/tb_noc_tx.sv

// File: run.sh
#!/bin/sh
# compile and run the noc_tx testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tb_noc_tx -o sim_noc_tx

./obj_dir/sim_noc_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
